//--- mips_core.f
rtl/mips_pkg.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/hazard_detection.sv
rtl/execution.sv
rtl/data_memory.sv
rtl/mips.sv
sim/mips_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the pipelined core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mips_tb -f mips_core.f -o mips_sim
./obj_dir/mips_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "result: pass"
else
    echo "result: fail"
    exit 1
fi

//--- sim/mips_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_tb;

    localparam int CLK_PERIOD      = 10;
    localparam int MAX_WORDS       = 33; // Clear programs are the longest
    localparam int NUM_TESTS       = 7;
    localparam int MAX_BOUND       = 3 * MAX_WORDS + 20;
    localparam int TEST_CYCLES     = MAX_WORDS + 8 + 2 * MAX_BOUND + 2 + 32 + 64;
    localparam int WATCHDOG_CYCLES = 5 + NUM_TESTS * TEST_CYCLES + 100;
    localparam int K_ALU           = 0;
    localparam int K_MEM           = 1;
    localparam int K_BRANCH        = 2;
    localparam int K_LINK          = 3;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_stall;
    logic                 i_inst_we;
    mips_pkg::imem_addr_t i_inst_addr;
    mips_pkg::word_t      i_inst_data;
    mips_pkg::reg_addr_t  i_dbg_reg;
    mips_pkg::word_t      o_dbg_reg_data;
    mips_pkg::dmem_addr_t i_dbg_addr;
    mips_pkg::word_t      o_dbg_mem_data;

    logic [31:0]     lfsr_state = 32'd49;
    mips_pkg::word_t prog [mips_pkg::IMEM_DEPTH];
    mips_pkg::word_t mem_prog [mips_pkg::IMEM_DEPTH];
    int              prog_len;
    int              mem_len;
    mips_pkg::word_t model_regs [mips_pkg::NUM_REGS];
    mips_pkg::word_t model_mem [mips_pkg::DMEM_DEPTH];
    int              errors       = 0;
    int              checks       = 0;
    int              tests_run    = 0;
    int              tests_failed = 0;

    mips dut0 (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_stall        (i_stall),
        .i_inst_we      (i_inst_we),
        .i_inst_addr    (i_inst_addr),
        .i_inst_data    (i_inst_data),
        .i_dbg_reg      (i_dbg_reg),
        .o_dbg_reg_data (o_dbg_reg_data),
        .i_dbg_addr     (i_dbg_addr),
        .o_dbg_mem_data (o_dbg_mem_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout: simulation ran past %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // Right-shift Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'hB4BC_D35C;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int rand_range(input int m);
        return int'(rand_bits(8)) % m;
    endfunction

    // Small register pool so that neighbours depend on each other
    function automatic mips_pkg::reg_addr_t pick_reg();
        mips_pkg::reg_addr_t r;
        r = mips_pkg::reg_addr_t'(rand_bits(3));
        if (r == 5'd7) begin
            r = mips_pkg::REG_RA; // Link register joins the chains
        end
        return r;
    endfunction

    function automatic mips_pkg::word_t enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd,
                                              input logic [4:0] sh);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t enc_j(input logic [5:0] op, input int target);
        return {op, 20'b0, 6'(target)};
    endfunction

    function automatic mips_pkg::word_t rand_alu_instr();
        mips_pkg::word_t w;
        logic [15:0]     imm;
        imm = 16'(rand_bits(16));
        case (rand_range(10))
            0: w = enc_r(mips_pkg::FN_ADD, pick_reg(), pick_reg(), pick_reg(), 5'd0);
            1: w = enc_r(mips_pkg::FN_SUB, pick_reg(), pick_reg(), pick_reg(), 5'd0);
            2: w = enc_r(mips_pkg::FN_AND, pick_reg(), pick_reg(), pick_reg(), 5'd0);
            3: w = enc_r(mips_pkg::FN_OR, pick_reg(), pick_reg(), pick_reg(), 5'd0);
            4: w = enc_r(mips_pkg::FN_XOR, pick_reg(), pick_reg(), pick_reg(), 5'd0);
            5: w = enc_r(mips_pkg::FN_SLT, pick_reg(), pick_reg(), pick_reg(), 5'd0);
            6: w = enc_r(mips_pkg::FN_SLL, 5'd0, pick_reg(), pick_reg(), 5'(rand_bits(5)));
            7: w = enc_i(mips_pkg::OP_ADDI, pick_reg(), pick_reg(), imm);
            8: w = enc_i(mips_pkg::OP_ANDI, pick_reg(), pick_reg(), imm);
            default: w = enc_i(mips_pkg::OP_ORI, pick_reg(), pick_reg(), imm);
        endcase
        return w;
    endfunction

    function automatic mips_pkg::reg_addr_t mem_base();
        return lfsr_bit() ? pick_reg() : 5'd0;
    endfunction

    // 32 stores of r0 then a jump to itself
    task automatic gen_clear(input int base);
        for (int k = 0; k < 32; k++) begin
            prog[k] = enc_i(mips_pkg::OP_SW, 5'd0, 5'd0, 16'(base + k));
        end
        prog[32] = enc_j(mips_pkg::OP_J, 32);
        prog_len = 33;
    endtask

    task automatic gen_program(input int kind);
        int                  n;
        int                  i;
        int                  sel;
        mips_pkg::reg_addr_t r;
        n = 22 + int'(rand_bits(3));
        i = 0;
        while (i < n - 1) begin
            sel = rand_range(4);
            if (kind == K_MEM && sel == 0 && i < n - 2) begin
                r = pick_reg();
                prog[i]     = enc_i(mips_pkg::OP_LW, mem_base(), r, 16'(rand_bits(3)));
                prog[i + 1] = enc_r(mips_pkg::FN_ADD, r, pick_reg(), pick_reg(), 5'd0);
                i += 2; // Load used right away
            end else if (kind == K_MEM && sel == 1) begin
                prog[i] = enc_i(mips_pkg::OP_SW, mem_base(), pick_reg(), 16'(rand_bits(3)));
                i++;
            end else if (kind == K_BRANCH && sel == 0) begin
                r = pick_reg();
                prog[i] = enc_i(lfsr_bit() ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ, r,
                                (rand_bits(2) == 0) ? r : pick_reg(),
                                16'(rand_range(n - 1 - i))); // Forward up to the last word
                i++;
            end else if (kind == K_LINK && sel == 0) begin
                prog[i] = enc_j(lfsr_bit() ? mips_pkg::OP_JAL : mips_pkg::OP_J,
                                i + 1 + rand_range(n - 1 - i));
                i++;
            end else begin
                prog[i] = rand_alu_instr();
                i++;
            end
        end
        prog[n - 1] = enc_j(mips_pkg::OP_J, n - 1);
        prog_len = n;
    endtask

    task automatic set_reg(input mips_pkg::reg_addr_t r, input mips_pkg::word_t v);
        if (r != 5'd0) begin
            model_regs[r] = v;
        end
    endtask

    // Instruction-level reference without a delay slot
    task automatic run_model();
        int                  pc;
        int                  next;
        int                  steps;
        logic                done;
        mips_pkg::word_t     w;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     imm_s;
        mips_pkg::word_t     imm_z;
        mips_pkg::word_t     ea;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 256) begin
            w     = prog[pc];
            rt    = w[20:16];
            rd    = w[15:11];
            a     = model_regs[w[25:21]];
            b     = model_regs[rt];
            imm_s = {{16{w[15]}}, w[15:0]};
            imm_z = {16'b0, w[15:0]};
            ea    = a + imm_s;
            next  = (pc + 1) % 64;
            case (w[31:26])
                mips_pkg::OP_RTYPE: begin
                    case (w[5:0])
                        mips_pkg::FN_ADD: set_reg(rd, a + b);
                        mips_pkg::FN_SUB: set_reg(rd, a - b);
                        mips_pkg::FN_AND: set_reg(rd, a & b);
                        mips_pkg::FN_OR:  set_reg(rd, a | b);
                        mips_pkg::FN_XOR: set_reg(rd, a ^ b);
                        mips_pkg::FN_SLT: set_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        mips_pkg::FN_SLL: set_reg(rd, b << w[10:6]);
                        default: ;
                    endcase
                end
                mips_pkg::OP_ADDI: set_reg(rt, a + imm_s);
                mips_pkg::OP_ANDI: set_reg(rt, a & imm_z);
                mips_pkg::OP_ORI:  set_reg(rt, a | imm_z);
                mips_pkg::OP_LW:   set_reg(rt, model_mem[ea[5:0]]);
                mips_pkg::OP_SW:   model_mem[ea[5:0]] = b;
                mips_pkg::OP_BEQ: begin
                    if (a == b) begin
                        next = (pc + 1 + int'($signed(imm_s))) % 64;
                    end
                end
                mips_pkg::OP_BNE: begin
                    if (a != b) begin
                        next = (pc + 1 + int'($signed(imm_s))) % 64;
                    end
                end
                mips_pkg::OP_J:   next = int'(w[5:0]);
                mips_pkg::OP_JAL: begin
                    set_reg(mips_pkg::REG_RA, 32'(pc + 1));
                    next = int'(w[5:0]);
                end
                default: ;
            endcase
            done = (next == pc); // Final jump to itself
            pc = next;
            steps++;
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    // Core held in reset while the program is written
    task automatic load_program();
        i_rst = 1'b1;
        for (int k = 0; k < prog_len; k++) begin
            next_cycle();
            i_inst_we   = 1'b1;
            i_inst_addr = mips_pkg::imem_addr_t'(k);
            i_inst_data = prog[k];
        end
        next_cycle();
        i_inst_we = 1'b0;
        repeat (5) next_cycle();
        i_rst = 1'b0;
    endtask

    task automatic check_word(input string test, input string what, input int idx,
                              input mips_pkg::word_t exp, input mips_pkg::word_t act);
        checks++;
        assert (act === exp) else begin
            $display("error %s %s[%0d]: expected 0x%08h actual 0x%08h",
                     test, what, idx, exp, act);
            errors++;
        end
    endtask

    task automatic run_test(input string name, input logic use_stall);
        int bound;
        int active;
        int freeze_cycles;
        int errors_before;
        errors_before = errors;
        for (int r = 0; r < mips_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0; // Reset clears the register file
        end
        run_model();
        load_program();
        bound         = 3 * prog_len + 20;
        active        = 0;
        freeze_cycles = 0;
        while (active < bound) begin
            next_cycle();
            if (use_stall && freeze_cycles < bound) begin
                i_stall = lfsr_bit();
            end else begin
                i_stall = 1'b0;
            end
            if (i_stall) begin
                freeze_cycles++;
            end else begin
                active++;
            end
        end
        next_cycle();
        i_stall = 1'b0;
        for (int r = 0; r < mips_pkg::NUM_REGS; r++) begin
            next_cycle();
            i_dbg_reg = mips_pkg::reg_addr_t'(r);
            #2;
            check_word(name, "reg", r, model_regs[r], o_dbg_reg_data);
        end
        for (int m = 0; m < mips_pkg::DMEM_DEPTH; m++) begin
            next_cycle();
            i_dbg_addr = mips_pkg::dmem_addr_t'(m);
            #2;
            check_word(name, "mem", m, model_mem[m], o_dbg_mem_data);
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %-8s words=%0d run=%0d freeze=%0d errors=%0d %s", name, prog_len,
                 bound, freeze_cycles, errors - errors_before,
                 (errors == errors_before) ? "ok" : "bad");
    endtask

    initial begin
        i_rst       = 1'b1;
        i_stall     = 1'b0;
        i_inst_we   = 1'b0;
        i_inst_addr = '0;
        i_inst_data = '0;
        i_dbg_reg   = '0;
        i_dbg_addr  = '0;
        repeat (5) next_cycle();
        i_rst = 1'b0;

        gen_clear(0);
        run_test("clear_lo", 1'b0);
        gen_clear(32);
        run_test("clear_hi", 1'b0);
        gen_program(K_ALU);
        run_test("alu", 1'b0);
        gen_program(K_MEM);
        mem_prog = prog; // Kept for the freeze rerun
        mem_len  = prog_len;
        run_test("memory", 1'b0);
        gen_program(K_BRANCH);
        run_test("branch", 1'b0);
        gen_program(K_LINK);
        run_test("link", 1'b0);
        prog     = mem_prog;
        prog_len = mem_len;
        run_test("freeze", 1'b1);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/mips.sv
`timescale 1ns/1ps
`default_nettype none

module mips (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_stall,
    input  wire logic                 i_inst_we,
    input  wire mips_pkg::imem_addr_t i_inst_addr,
    input  wire mips_pkg::word_t      i_inst_data,
    input  wire mips_pkg::reg_addr_t  i_dbg_reg,
    output mips_pkg::word_t           o_dbg_reg_data,
    input  wire mips_pkg::dmem_addr_t i_dbg_addr,
    output mips_pkg::word_t           o_dbg_mem_data
);

    logic                 frozen;
    logic                 hazard;
    logic                 flush;
    logic                 dec_redirect;
    logic                 dec_is_jump_or_branch;
    mips_pkg::imem_addr_t dec_target;
    mips_pkg::word_t      f_instr;
    mips_pkg::imem_addr_t f_pc_plus1;
    mips_pkg::if_id_t     if_id;
    mips_pkg::id_ex_t     id_ex;
    mips_pkg::id_ex_t     dec_id_ex;
    mips_pkg::ex_mem_t    ex_mem;
    mips_pkg::mem_wb_t    mem_wb;
    mips_pkg::word_t      ex_result;
    mips_pkg::word_t      ex_store_data;
    mips_pkg::reg_addr_t  ex_dst;
    mips_pkg::word_t      dm_read_data;
    mips_pkg::word_t      wb_data;

    assign frozen = i_stall | i_inst_we; // Whole core stops while loading

    instruction_fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_hold      (frozen | hazard),
        .i_redirect  (flush),
        .i_target    (dec_target),
        .i_inst_we   (i_inst_we),
        .i_inst_addr (i_inst_addr),
        .i_inst_data (i_inst_data),
        .o_instr     (f_instr),
        .o_pc_plus1  (f_pc_plus1)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            if_id <= '0;
        end else if (!frozen && !hazard) begin
            if (flush) begin
                if_id <= '0; // Drop the word behind a taken branch
            end else begin
                if_id.instr    <= f_instr;
                if_id.pc_plus1 <= f_pc_plus1;
            end
        end
    end

    instruction_decode u_decode (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .i_freeze            (frozen),
        .i_if_id             (if_id),
        .i_id_ex             (id_ex),
        .i_ex_result         (ex_result),
        .i_ex_dst            (ex_dst),
        .i_ex_mem            (ex_mem),
        .i_mem_read_data     (dm_read_data),
        .i_wb_we             (mem_wb.reg_write),
        .i_wb_dst            (mem_wb.dst),
        .i_wb_data           (wb_data),
        .i_dbg_reg           (i_dbg_reg),
        .o_id_ex             (dec_id_ex),
        .o_redirect          (dec_redirect),
        .o_target            (dec_target),
        .o_is_jump_or_branch (dec_is_jump_or_branch),
        .o_dbg_reg_data      (o_dbg_reg_data)
    );

    hazard_detection u_hazard (
        .i_rs       (dec_id_ex.rs),
        .i_rt       (dec_id_ex.rt),
        .i_id_ex    (id_ex),
        .i_redirect (dec_redirect & dec_is_jump_or_branch),
        .o_hazard   (hazard),
        .o_flush    (flush)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            id_ex <= '0;
        end else if (!frozen) begin
            id_ex <= hazard ? '0 : dec_id_ex; // Bubble on load-use
        end
    end

    execution u_exec (
        .i_id_ex      (id_ex),
        .o_result     (ex_result),
        .o_store_data (ex_store_data),
        .o_dst        (ex_dst)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ex_mem <= '0;
        end else if (!frozen) begin
            ex_mem.result     <= ex_result;
            ex_mem.store_data <= ex_store_data;
            ex_mem.dst        <= ex_dst;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

    data_memory u_dmem (
        .i_clk          (i_clk),
        .i_we           (ex_mem.ctrl.mem_write & ~frozen),
        .i_addr         (ex_mem.result[$bits(mips_pkg::dmem_addr_t)-1:0]),
        .i_write_data   (ex_mem.store_data),
        .i_dbg_addr     (i_dbg_addr),
        .o_read_data    (dm_read_data),
        .o_dbg_mem_data (o_dbg_mem_data)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem_wb <= '0;
        end else if (!frozen) begin
            mem_wb.result     <= ex_mem.result;
            mem_wb.load_data  <= dm_read_data;
            mem_wb.dst        <= ex_mem.dst;
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
        end
    end

    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

endmodule

`default_nettype wire

//--- rtl/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory (
    input  wire logic                 i_clk,
    input  wire logic                 i_we,
    input  wire mips_pkg::dmem_addr_t i_addr,
    input  wire mips_pkg::word_t      i_write_data,
    input  wire mips_pkg::dmem_addr_t i_dbg_addr,
    output mips_pkg::word_t           o_read_data,
    output mips_pkg::word_t           o_dbg_mem_data
);

    mips_pkg::word_t mem [mips_pkg::DMEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_write_data;
        end
    end

    assign o_read_data    = mem[i_addr];     // Load path
    assign o_dbg_mem_data = mem[i_dbg_addr]; // Debug readback

endmodule

`default_nettype wire

//--- rtl/execution.sv
`timescale 1ns/1ps
`default_nettype none

module execution (
    input  wire mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::word_t        o_result,
    output mips_pkg::word_t        o_store_data,
    output mips_pkg::reg_addr_t    o_dst
);

    mips_pkg::word_t src_a;
    mips_pkg::word_t src_b;
    mips_pkg::word_t alu_res;

    // sll shifts rt by shamt
    assign src_a = i_id_ex.ctrl.shift_src ? i_id_ex.b : i_id_ex.a;

    always_comb begin
        if (i_id_ex.ctrl.alu_src) begin
            src_b = i_id_ex.imm;
        end else if (i_id_ex.ctrl.shift_src) begin
            src_b = {27'b0, i_id_ex.shamt};
        end else begin
            src_b = i_id_ex.b;
        end
    end

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_res = src_a + src_b;
            mips_pkg::ALU_SUB: alu_res = src_a - src_b;
            mips_pkg::ALU_AND: alu_res = src_a & src_b;
            mips_pkg::ALU_OR:  alu_res = src_a | src_b;
            mips_pkg::ALU_XOR: alu_res = src_a ^ src_b;
            mips_pkg::ALU_SLT: alu_res = {31'b0, $signed(src_a) < $signed(src_b)};
            mips_pkg::ALU_SLL: alu_res = src_a << src_b[4:0];
            default:           alu_res = '0;
        endcase
    end

    assign o_result     = i_id_ex.ctrl.link ? mips_pkg::word_t'(i_id_ex.pc_plus1) : alu_res;
    assign o_store_data = i_id_ex.b;

    always_comb begin
        if (i_id_ex.ctrl.link) begin
            o_dst = mips_pkg::REG_RA;
        end else if (i_id_ex.ctrl.reg_dst) begin
            o_dst = i_id_ex.rd;
        end else begin
            o_dst = i_id_ex.rt; // I-type writes rt
        end
    end

endmodule

`default_nettype wire

//--- rtl/hazard_detection.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detection (
    input  wire mips_pkg::reg_addr_t i_rs,
    input  wire mips_pkg::reg_addr_t i_rt,
    input  wire mips_pkg::id_ex_t    i_id_ex,
    input  wire logic                i_redirect,
    output logic                     o_hazard,
    output logic                     o_flush
);

    logic load_in_ex;

    assign load_in_ex = i_id_ex.ctrl.mem_read && (i_id_ex.rt != '0);

    // Load data is not ready until the load reaches memory
    assign o_hazard = load_in_ex && (i_id_ex.rt == i_rs || i_id_ex.rt == i_rt);

    // Branch outcome may still depend on the pending load
    assign o_flush = i_redirect && !o_hazard;

endmodule

`default_nettype wire

//--- rtl/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_freeze,
    input  wire mips_pkg::if_id_t     i_if_id,
    input  wire mips_pkg::id_ex_t     i_id_ex,
    input  wire mips_pkg::word_t      i_ex_result,
    input  wire mips_pkg::reg_addr_t  i_ex_dst,
    input  wire mips_pkg::ex_mem_t    i_ex_mem,
    input  wire mips_pkg::word_t      i_mem_read_data,
    input  wire logic                 i_wb_we,
    input  wire mips_pkg::reg_addr_t  i_wb_dst,
    input  wire mips_pkg::word_t      i_wb_data,
    input  wire mips_pkg::reg_addr_t  i_dbg_reg,
    output mips_pkg::id_ex_t          o_id_ex,
    output logic                      o_redirect,
    output mips_pkg::imem_addr_t      o_target,
    output logic                      o_is_jump_or_branch,
    output mips_pkg::word_t           o_dbg_reg_data
);

    mips_pkg::word_t     regs [mips_pkg::NUM_REGS];
    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [15:0]         imm16;
    mips_pkg::word_t     imm_ext;
    mips_pkg::word_t     op_a;
    mips_pkg::word_t     op_b;
    mips_pkg::ctrl_t     ctrl;
    logic                zero_ext;
    logic                is_jump;
    logic                is_branch;

    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign funct  = i_if_id.instr[5:0];
    assign imm16  = i_if_id.instr[15:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_we && !i_freeze && i_wb_dst != '0) begin
            regs[i_wb_dst] <= i_wb_data;
        end
    end

    // Youngest producer first and r0 never forwarded
    function automatic mips_pkg::word_t fwd(input mips_pkg::reg_addr_t r);
        mips_pkg::word_t val;
        if (r == '0) begin
            val = '0;
        end else if (i_id_ex.ctrl.reg_write && i_ex_dst == r) begin
            val = i_ex_result;
        end else if (i_ex_mem.ctrl.reg_write && i_ex_mem.dst == r) begin
            val = i_ex_mem.ctrl.mem_to_reg ? i_mem_read_data : i_ex_mem.result;
        end else if (i_wb_we && i_wb_dst == r) begin
            val = i_wb_data;
        end else begin
            val = regs[r];
        end
        return val;
    endfunction

    always_comb begin
        ctrl      = '0;
        zero_ext  = 1'b0;
        is_jump   = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (funct)
                    mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: begin
                        ctrl.alu_op    = mips_pkg::ALU_SLL;
                        ctrl.shift_src = 1'b1;
                    end
                    default: ctrl = '0; // Unsupported funct acts as a nop
                endcase
            end
            mips_pkg::OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_ANDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::ALU_AND;
                zero_ext       = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::ALU_OR;
                zero_ext       = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: is_branch = 1'b1;
            mips_pkg::OP_J:                     is_jump   = 1'b1;
            mips_pkg::OP_JAL: begin
                is_jump        = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.link      = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assign imm_ext = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        op_a = fwd(rs);
        op_b = fwd(rt);
    end

    // Raw condition that the top qualifies by instruction class
    always_comb begin
        if (is_jump) begin
            o_redirect = 1'b1;
        end else if (opcode == mips_pkg::OP_BNE) begin
            o_redirect = (op_a != op_b);
        end else begin
            o_redirect = (op_a == op_b);
        end
    end

    assign o_is_jump_or_branch = is_jump | is_branch;
    assign o_target = is_jump ? i_if_id.instr[$bits(mips_pkg::imem_addr_t)-1:0]
                              : i_if_id.pc_plus1 + imm_ext[$bits(mips_pkg::imem_addr_t)-1:0];

    always_comb begin
        o_id_ex.rs       = rs;
        o_id_ex.rt       = rt;
        o_id_ex.rd       = rd;
        o_id_ex.a        = op_a;
        o_id_ex.b        = op_b;
        o_id_ex.imm      = imm_ext;
        o_id_ex.shamt    = i_if_id.instr[10:6];
        o_id_ex.pc_plus1 = i_if_id.pc_plus1;
        o_id_ex.ctrl     = ctrl;
    end

    assign o_dbg_reg_data = (i_dbg_reg == '0) ? '0 : regs[i_dbg_reg];

endmodule

`default_nettype wire

//--- rtl/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_hold,
    input  wire logic                 i_redirect,
    input  wire mips_pkg::imem_addr_t i_target,
    input  wire logic                 i_inst_we,
    input  wire mips_pkg::imem_addr_t i_inst_addr,
    input  wire mips_pkg::word_t      i_inst_data,
    output mips_pkg::word_t           o_instr,
    output mips_pkg::imem_addr_t      o_pc_plus1
);

    mips_pkg::word_t      imem [mips_pkg::IMEM_DEPTH];
    mips_pkg::imem_addr_t pc;

    // Program load port
    always_ff @(posedge i_clk) begin
        if (i_inst_we) begin
            imem[i_inst_addr] <= i_inst_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (!i_hold) begin
            pc <= i_redirect ? i_target : o_pc_plus1; // Taken branch or jump wins
        end
    end

    assign o_pc_plus1 = pc + 1'b1; // Word addressed PC
    assign o_instr    = imem[pc];

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  imem_addr_t;
    typedef logic [5:0]  dmem_addr_t;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int NUM_REGS   = 32;

    localparam reg_addr_t REG_RA = 5'd31; // Link register

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;

    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2A;

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;
    localparam alu_op_t ALU_SLL = 3'd6;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;   // Operand b from immediate
        logic    shift_src; // Shift amount from shamt
        logic    reg_dst;   // Destination is rd
        logic    link;      // Write PC+1 into r31
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t      instr;
        imem_addr_t pc_plus1;
    } if_id_t;

    typedef struct packed {
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm;
        logic [4:0] shamt;
        imem_addr_t pc_plus1;
        ctrl_t      ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t dst;
        ctrl_t     ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        word_t     load_data;
        reg_addr_t dst;
        logic      reg_write;
        logic      mem_to_reg;
    } mem_wb_t;

endpackage

`default_nettype wire
